// ==== verilog.f ====
ofdm_payload_pkg.sv
mapped_group_if.sv
bit_packer.sv
constellation_mapper.sv
symbol_buffer.sv
subcarrier_assembler.sv
ofdm_payload_gen.sv
ofdm_payload_gen_sva.sv
tb_ofdm_payload_gen.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_ofdm_payload_gen -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb_ofdm_payload_gen.sv ====
`timescale 1ns/1ps

module tb_ofdm_payload_gen;
    import ofdm_payload_pkg::*;

    localparam int TOTAL_BYTES = 24 + 48 + 96 + 96 + 24 + 48;
    localparam int TOTAL_BINS  = 6 * N_BINS;
    localparam int MAX_CYCLES  = (TOTAL_BYTES + TOTAL_BINS) * 3 / 2 + 1000;
    localparam int PILOT_BINS [8] = '{13, 38, 63, 88, 168, 193, 218, 243};

    logic       clk;
    logic       reset;
    logic       byte_valid_i;
    byte_t      byte_i;
    mod_t       modulation_i;
    logic       out_ready_i;
    logic       out_valid_o;
    sample_t    out_i_o;
    sample_t    out_q_o;
    bin_index_t bin_index_o;
    logic       symbol_done_o;

    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          cycle_count;
    byte_t       payload [$];
    sample_t     exp_i [N_DATA];
    sample_t     exp_q [N_DATA];

    ofdm_payload_gen i_ofdm_payload_gen (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // random bytes and compare tasks
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    task automatic lfsr_bit(output logic b);
        b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
    endtask

    task automatic random_byte(output byte_t value);
        logic b;
        for (int i = 0; i < 8; i++)
        begin
            lfsr_bit(b);
            value = {value[6:0], b};
        end
    endtask

    task automatic compare_sample(input string name, input sample_t actual,
                                  input sample_t expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic compare_bin(input string name, input bin_index_t actual,
                               input bin_index_t expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // msb gives the sign and lsb picks the inner level
    function automatic sample_t gray_level(input logic [1:0] code);
        sample_t magnitude;
        magnitude = code[0] ? QAM16_LOW : QAM16_HIGH;
        return code[1] ? -magnitude : magnitude;
    endfunction

    // the payload is one bit stream starting at the lsb of byte 0
    task automatic build_model(input mod_t mod);
        int         bpp;
        logic [3:0] code;
        bpp = (mod == MOD_QAM16) ? 4 : (mod == MOD_QPSK) ? 2 : 1;
        for (int n = 0; n < N_DATA; n++)
        begin
            code = '0;
            for (int b = 0; b < bpp; b++)
            begin
                code[b] = payload[(n * bpp + b) / 8][(n * bpp + b) % 8];
            end
            case (mod)
                MOD_QAM16:
                begin
                    exp_i[n] = gray_level(code[1:0]);
                    exp_q[n] = gray_level(code[3:2]);
                end
                MOD_QPSK:
                begin
                    exp_i[n] = code[0] ? -QPSK_AMP : QPSK_AMP;
                    exp_q[n] = code[1] ? -QPSK_AMP : QPSK_AMP;
                end
                default:
                begin
                    exp_i[n] = code[0] ? -BPSK_AMP : BPSK_AMP;
                    exp_q[n] = 16'sd0;
                end
            endcase
        end
    endtask

    task automatic expected_bin(input int bin, inout int data_n,
                                output sample_t ei, output sample_t eq);
        logic is_pilot;
        is_pilot = 1'b0;
        for (int p = 0; p < 8; p++)
        begin
            if (PILOT_BINS[p] == bin)
            begin
                is_pilot = 1'b1;
            end
        end
        eq = 16'sd0;
        if (bin == 0 || (bin >= 101 && bin <= 155))
        begin
            ei = 16'sd0;
        end
        else if (is_pilot)
        begin
            ei = (bin < 128) ? PILOT_AMP : -PILOT_AMP;
        end
        else
        begin
            ei = exp_i[data_n];
            eq = exp_q[data_n];
            data_n++;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus and symbol checking
    //////////////////////////////////////////////////

    task automatic make_payload(input int n_bytes);
        byte_t value;
        payload.delete();
        for (int i = 0; i < n_bytes; i++)
        begin
            random_byte(value);
            payload.push_back(value);
        end
    endtask

    task automatic send_payload(input mod_t mod);
        @(posedge clk);
        modulation_i <= mod;
        build_model(mod);
        foreach (payload[i])
        begin
            @(posedge clk);
            byte_valid_i <= 1'b1;
            byte_i       <= payload[i];
        end
        @(posedge clk);
        byte_valid_i <= 1'b0;
    endtask

    // junk bytes start once the symbol is full and streaming
    task automatic collect_symbol(input bit random_ready, input bit junk);
        int      bins_seen;
        int      data_n;
        logic    rdy;
        bit      started;
        bit      done;
        byte_t   junk_byte;
        sample_t ei;
        sample_t eq;
        bins_seen = 0;
        data_n    = 0;
        started   = 0;
        done      = 0;
        while (!done)
        begin
            @(posedge clk);
            rdy = 1'b1;
            if (random_ready)
            begin
                lfsr_bit(rdy);
            end
            out_ready_i <= rdy;
            if (junk && started)
            begin
                random_byte(junk_byte);
                byte_valid_i <= 1'b1;
                byte_i       <= junk_byte;
            end
            @(negedge clk);
            if (out_valid_o)
            begin
                started = 1;
                if (bins_seen >= N_BINS)
                begin
                    error_count++;
                    $display("an extra bin came out after bin 255");
                end
                else
                begin
                    expected_bin(bins_seen, data_n, ei, eq);
                    compare_bin("bin_index_o", bin_index_o, bin_index_t'(bins_seen));
                    compare_sample("out_i_o", out_i_o, ei);
                    compare_sample("out_q_o", out_q_o, eq);
                end
                bins_seen++;
            end
            done = symbol_done_o;
        end
        if (bins_seen != N_BINS)
        begin
            error_count++;
            $display("symbol ended after %0d bins instead of %0d", bins_seen, N_BINS);
        end
        @(posedge clk);
        byte_valid_i <= 1'b0;
        out_ready_i  <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic bpsk_symbol();
        make_payload(24);
        send_payload(MOD_BPSK);
        collect_symbol(0, 0);
    endtask

    task automatic qpsk_symbol();
        make_payload(48);
        send_payload(MOD_QPSK);
        collect_symbol(0, 0);
    endtask

    // first eight bytes hold every nibble code once
    task automatic qam16_all_codes();
        make_payload(96);
        for (int i = 0; i < 8; i++)
        begin
            payload[i] = {4'(2 * i + 1), 4'(2 * i)};
        end
        send_payload(MOD_QAM16);
        collect_symbol(0, 0);
    endtask

    task automatic back_pressure();
        make_payload(96);
        send_payload(MOD_QAM16);
        collect_symbol(1, 0);
    endtask

    task automatic bytes_during_output();
        make_payload(24);
        send_payload(MOD_BPSK);
        collect_symbol(0, 1);
        make_payload(48);
        send_payload(MOD_QPSK);
        collect_symbol(0, 0);
    endtask

    initial
    begin
        reset        = 1'b1;
        byte_valid_i = 1'b0;
        byte_i       = '0;
        modulation_i = MOD_BPSK;
        out_ready_i  = 1'b1;
        lfsr         = 32'hf447_e9ab;
        error_count  = 0;
        check_count  = 0;
        cycle_count  = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        bpsk_symbol();
        qpsk_symbol();
        qam16_all_codes();
        back_pressure();
        bytes_during_output();
        @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== ofdm_payload_gen_sva.sv ====
`timescale 1ns/1ps

module ofdm_payload_gen_sva (
    input logic                         clk,
    input logic                         reset,
    input logic                         byte_valid_i,
    input logic                         out_ready_i,
    input logic                         out_valid_o,
    input ofdm_payload_pkg::bin_index_t bin_index_o,
    input logic                         symbol_done_o
);
    import ofdm_payload_pkg::*;

    logic bytes_seen;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bytes_seen <= 1'b0;
        end
        else if (byte_valid_i)
        begin
            bytes_seen <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // output protocol
    //////////////////////////////////////////////////

    quiet_until_bytes: assert property (@(posedge clk) disable iff (reset)
        !bytes_seen |-> (!out_valid_o && !symbol_done_o))
        else $error("output active before any byte arrived");

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        symbol_done_o |=> !symbol_done_o)
        else $error("symbol_done_o high for more than one cycle");

    // valid is registered from ready
    no_valid_after_stall: assert property (@(posedge clk) disable iff (reset)
        !out_ready_i |=> !out_valid_o)
        else $error("out_valid_o high after a cycle with out_ready_i low");

    done_after_last_bin: assert property (@(posedge clk) disable iff (reset)
        (out_valid_o && bin_index_o == bin_index_t'(N_BINS - 1)) |=> symbol_done_o)
        else $error("symbol_done_o missing after bin 255");

endmodule

bind ofdm_payload_gen ofdm_payload_gen_sva i_ofdm_payload_gen_sva (.*);

// ==== ofdm_payload_gen.sv ====
`timescale 1ns/1ps

module ofdm_payload_gen (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         byte_valid_i,
    input  ofdm_payload_pkg::byte_t      byte_i,
    input  ofdm_payload_pkg::mod_t       modulation_i,
    input  logic                         out_ready_i,
    output logic                         out_valid_o,
    output ofdm_payload_pkg::sample_t    out_i_o,
    output ofdm_payload_pkg::sample_t    out_q_o,
    output ofdm_payload_pkg::bin_index_t bin_index_o,
    output logic                         symbol_done_o
);
    import ofdm_payload_pkg::*;

    logic        group_valid;
    group_word_t group_word;
    logic        full;
    logic        release_sym;
    data_index_t rd_index;
    sample_t     rd_i;
    sample_t     rd_q;

    mapped_group_if grp ();

    //////////////////////////////////////////////////
    // bytes to buffered points
    //////////////////////////////////////////////////

    bit_packer i_bit_packer (
        .clk           (clk),
        .reset         (reset),
        .byte_valid_i  (byte_valid_i),
        .byte_i        (byte_i),
        .modulation_i  (modulation_i),
        .full_i        (full),
        .group_valid_o (group_valid),
        .group_word_o  (group_word)
    );

    constellation_mapper i_constellation_mapper (
        .clk           (clk),
        .reset         (reset),
        .group_valid_i (group_valid),
        .group_word_i  (group_word),
        .modulation_i  (modulation_i),
        .grp           (grp.mapper)
    );

    symbol_buffer i_symbol_buffer (
        .clk        (clk),
        .reset      (reset),
        .grp        (grp.buffer),
        .release_i  (release_sym),
        .rd_index_i (rd_index),
        .rd_i_o     (rd_i),
        .rd_q_o     (rd_q),
        .full_o     (full)
    );

    //////////////////////////////////////////////////
    // symbol output
    //////////////////////////////////////////////////

    subcarrier_assembler i_subcarrier_assembler (
        .clk           (clk),
        .reset         (reset),
        .full_i        (full),
        .out_ready_i   (out_ready_i),
        .rd_index_o    (rd_index),
        .rd_i_i        (rd_i),
        .rd_q_i        (rd_q),
        .out_valid_o   (out_valid_o),
        .out_i_o       (out_i_o),
        .out_q_o       (out_q_o),
        .bin_index_o   (bin_index_o),
        .release_o     (release_sym),
        .symbol_done_o (symbol_done_o)
    );

endmodule

// ==== subcarrier_assembler.sv ====
`timescale 1ns/1ps

module subcarrier_assembler (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          full_i,
    input  logic                          out_ready_i,
    output ofdm_payload_pkg::data_index_t rd_index_o,
    input  ofdm_payload_pkg::sample_t     rd_i_i,
    input  ofdm_payload_pkg::sample_t     rd_q_i,
    output logic                          out_valid_o,
    output ofdm_payload_pkg::sample_t     out_i_o,
    output ofdm_payload_pkg::sample_t     out_q_o,
    output ofdm_payload_pkg::bin_index_t  bin_index_o,
    output logic                          release_o,
    output logic                          symbol_done_o
);
    import ofdm_payload_pkg::*;

    localparam bin_index_t LAST_BIN = bin_index_t'(N_BINS - 1);

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DONE
    } state_t;

    state_t      state;
    bin_index_t  bin_cnt;
    data_index_t data_idx;
    bin_kind_t   kind;
    sample_t     bin_i;
    sample_t     bin_q;
    logic        send;

    assign send       = (state == STREAM) && out_ready_i;
    assign rd_index_o = data_idx;

    //////////////////////////////////////////////////
    // bin contents
    //////////////////////////////////////////////////

    always_comb
    begin
        kind = bin_kind(bin_cnt);
        case (kind)
            BIN_PILOT:
            begin
                bin_i = pilot_value(bin_cnt);
                bin_q = 16'sd0;
            end
            BIN_DATA:
            begin
                bin_i = rd_i_i;
                bin_q = rd_q_i;
            end
            default:
            begin
                bin_i = 16'sd0;
                bin_q = 16'sd0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= IDLE;
            bin_cnt       <= '0;
            data_idx      <= '0;
            bin_index_o   <= '0;
            out_valid_o   <= 1'b0;
            release_o     <= 1'b0;
            symbol_done_o <= 1'b0;
        end
        else
        begin
            out_valid_o   <= 1'b0;
            release_o     <= 1'b0;
            symbol_done_o <= 1'b0;
            case (state)
                IDLE:
                begin
                    // full is still high while the release is in flight
                    if (full_i && !release_o)
                    begin
                        state    <= STREAM;
                        bin_cnt  <= '0;
                        data_idx <= '0;
                    end
                end
                STREAM:
                begin
                    if (out_ready_i)
                    begin
                        out_valid_o <= 1'b1;
                        bin_index_o <= bin_cnt;
                        bin_cnt     <= bin_cnt + 8'd1;
                        if (kind == BIN_DATA)
                        begin
                            data_idx <= data_idx + 8'd1;
                        end
                        if (bin_cnt == LAST_BIN)
                        begin
                            state <= DONE;
                        end
                    end
                end
                DONE:
                begin
                    release_o     <= 1'b1;
                    symbol_done_o <= 1'b1;
                    state         <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // sample registers follow the bin they belong to
    always_ff @(posedge clk)
    begin
        if (send)
        begin
            out_i_o <= bin_i;
            out_q_o <= bin_q;
        end
    end

endmodule

// ==== symbol_buffer.sv ====
`timescale 1ns/1ps

module symbol_buffer (
    input  logic                          clk,
    input  logic                          reset,
    mapped_group_if.buffer                grp,
    input  logic                          release_i,
    input  ofdm_payload_pkg::data_index_t rd_index_i,
    output ofdm_payload_pkg::sample_t     rd_i_o,
    output ofdm_payload_pkg::sample_t     rd_q_o,
    output logic                          full_o
);
    import ofdm_payload_pkg::*;

    localparam data_index_t LAST_GROUP_PTR = data_index_t'(N_DATA - GROUP_POINTS);

    sample_t     mem_i [N_DATA];
    sample_t     mem_q [N_DATA];
    data_index_t wr_ptr;
    logic        wr_en;

    assign wr_en = grp.valid && !full_o;

    //////////////////////////////////////////////////
    // write pointer and full flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || release_i)
        begin
            wr_ptr <= '0;
            full_o <= 1'b0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + data_index_t'(GROUP_POINTS);
            // group 24 fills the symbol
            if (wr_ptr == LAST_GROUP_PTR)
            begin
                full_o <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // point storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int k = 0; k < GROUP_POINTS; k++)
            begin
                mem_i[wr_ptr + data_index_t'(k)] <= grp.point_i[k];
                mem_q[wr_ptr + data_index_t'(k)] <= grp.point_q[k];
            end
        end
    end

    // combinational read for the assembler
    assign rd_i_o = mem_i[rd_index_i];
    assign rd_q_o = mem_q[rd_index_i];

endmodule

// ==== constellation_mapper.sv ====
`timescale 1ns/1ps

module constellation_mapper (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          group_valid_i,
    input  ofdm_payload_pkg::group_word_t group_word_i,
    input  ofdm_payload_pkg::mod_t        modulation_i,
    mapped_group_if.mapper                grp
);
    import ofdm_payload_pkg::*;

    sample_t mapped_i [GROUP_POINTS];
    sample_t mapped_q [GROUP_POINTS];

    //////////////////////////////////////////////////
    // all eight points in parallel
    //////////////////////////////////////////////////

    // point k takes its bits from k * bits-per-point upward
    always_comb
    begin
        for (int k = 0; k < GROUP_POINTS; k++)
        begin
            mapped_i[k] = map_point_i(group_word_i, modulation_i, k);
            mapped_q[k] = map_point_q(group_word_i, modulation_i, k);
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grp.valid <= 1'b0;
        end
        else
        begin
            grp.valid <= group_valid_i;
        end
    end

    // points only change when a new group comes in
    always_ff @(posedge clk)
    begin
        if (group_valid_i)
        begin
            for (int k = 0; k < GROUP_POINTS; k++)
            begin
                grp.point_i[k] <= mapped_i[k];
                grp.point_q[k] <= mapped_q[k];
            end
        end
    end

endmodule

// ==== bit_packer.sv ====
`timescale 1ns/1ps

module bit_packer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         byte_valid_i,
    input  ofdm_payload_pkg::byte_t      byte_i,
    input  ofdm_payload_pkg::mod_t       modulation_i,
    input  logic                         full_i,
    output logic                         group_valid_o,
    output ofdm_payload_pkg::group_word_t group_word_o
);
    import ofdm_payload_pkg::*;

    logic [1:0] byte_cnt;
    logic [2:0] last_cnt;
    logic       accept;
    logic       last_byte;

    // bytes are dropped while the symbol is full or being sent
    assign accept    = byte_valid_i && !full_i;
    assign last_cnt  = bytes_per_group(modulation_i) - 3'd1;
    assign last_byte = ({1'b0, byte_cnt} == last_cnt);

    //////////////////////////////////////////////////
    // byte count and group strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt      <= 2'd0;
            group_valid_o <= 1'b0;
        end
        else
        begin
            group_valid_o <= 1'b0;
            if (accept)
            begin
                if (last_byte)
                begin
                    byte_cnt      <= 2'd0;
                    group_valid_o <= 1'b1;
                end
                else
                begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // group word
    //////////////////////////////////////////////////

    // byte 0 lands in the low bits
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            group_word_o[byte_cnt*8 +: 8] <= byte_i;
        end
    end

endmodule

// ==== mapped_group_if.sv ====
`timescale 1ns/1ps

interface mapped_group_if;
    import ofdm_payload_pkg::*;

    // one strobe per group of eight points
    logic    valid;
    sample_t point_i [GROUP_POINTS];
    sample_t point_q [GROUP_POINTS];

    modport mapper (
        output valid,
        output point_i,
        output point_q
    );

    // no back-pressure, buffer drops groups while full
    modport buffer (
        input valid,
        input point_i,
        input point_q
    );

endinterface

// ==== ofdm_payload_pkg.sv ====
package ofdm_payload_pkg;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic signed [15:0] sample_t;
    typedef logic [7:0]         byte_t;
    typedef logic [31:0]        group_word_t;
    typedef logic [7:0]         bin_index_t;
    typedef logic [7:0]         data_index_t;

    // code 3 falls back to bpsk
    typedef enum logic [1:0] {
        MOD_BPSK  = 2'd0,
        MOD_QPSK  = 2'd1,
        MOD_QAM16 = 2'd2
    } mod_t;

    typedef enum logic [1:0] {
        BIN_NULL,
        BIN_PILOT,
        BIN_DATA
    } bin_kind_t;

    //////////////////////////////////////////////////
    // symbol layout and amplitudes
    //////////////////////////////////////////////////

    localparam int GROUP_POINTS   = 8;
    localparam int N_DATA         = 192;
    localparam int N_BINS         = 256;
    localparam int LAST_USED_POS  = 100;
    localparam int FIRST_USED_NEG = 156;

    localparam sample_t BPSK_AMP   = 16'sd16384;
    localparam sample_t QPSK_AMP   = 16'sd11585;
    localparam sample_t QAM16_LOW  = 16'sd3663;
    localparam sample_t QAM16_HIGH = 16'sd10989;
    localparam sample_t PILOT_AMP  = 16'sd16384;

    // dc, guard band, pilots or data
    function automatic bin_kind_t bin_kind(input bin_index_t bin);
        bin_kind_t kind;
        if (bin == 0 || (bin > LAST_USED_POS && bin < FIRST_USED_NEG))
        begin
            kind = BIN_NULL;
        end
        else
        begin
            case (bin)
                8'd13, 8'd38, 8'd63, 8'd88,
                8'd168, 8'd193, 8'd218, 8'd243: kind = BIN_PILOT;
                default:                        kind = BIN_DATA;
            endcase
        end
        return kind;
    endfunction

    // I of a pilot bin, Q of a pilot is always zero
    function automatic sample_t pilot_value(input bin_index_t bin);
        return (bin < FIRST_USED_NEG) ? PILOT_AMP : -PILOT_AMP;
    endfunction

    function automatic logic [2:0] bytes_per_group(input mod_t mod);
        logic [2:0] n;
        case (mod)
            MOD_QPSK:  n = 3'd2;
            MOD_QAM16: n = 3'd4;
            default:   n = 3'd1;
        endcase
        return n;
    endfunction

    //////////////////////////////////////////////////
    // mapping rule
    //////////////////////////////////////////////////

    function automatic sample_t sign_level(input logic b, input sample_t amp);
        return b ? -amp : amp;
    endfunction

    // gray coded levels, msb is the sign
    function automatic sample_t qam16_level(input logic [1:0] code);
        sample_t level;
        case (code)
            2'b00:   level = QAM16_HIGH;
            2'b01:   level = QAM16_LOW;
            2'b11:   level = -QAM16_LOW;
            default: level = -QAM16_HIGH;
        endcase
        return level;
    endfunction

    function automatic sample_t map_point_i(input group_word_t word, input mod_t mod,
                                            input int k);
        sample_t value;
        case (mod)
            MOD_QPSK:  value = sign_level(word[2*k], QPSK_AMP);
            MOD_QAM16: value = qam16_level(word[4*k +: 2]);
            default:   value = sign_level(word[k], BPSK_AMP);
        endcase
        return value;
    endfunction

    function automatic sample_t map_point_q(input group_word_t word, input mod_t mod,
                                            input int k);
        sample_t value;
        case (mod)
            MOD_QPSK:  value = sign_level(word[2*k+1], QPSK_AMP);
            MOD_QAM16: value = qam16_level(word[4*k+2 +: 2]);
            default:   value = 16'sd0;
        endcase
        return value;
    endfunction

endpackage
